//--- flist.f
verilog/ldpc_vstep_pkg.sv
verilog/ldpc_vnode_sum.sv
verilog/ldpc_msg_fifo.sv
verilog/ldpc_vnode_update.sv
verilog/ldpc_hd_collect.sv
verilog/ldpc_vstep_top.sv
verification/ldpc_vstep_assertions.sv
verification/ldpc_vstep_tb.sv

//--- run.sh
#!/bin/sh
# build and run the vertical step testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module ldpc_vstep_tb -f flist.f --Mdir "$obj" -o vstep_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench can count them
"./$obj/vstep_sim" +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
  exit 1
fi
if ! grep -q "=== PASS ===" "$log"; then
  echo "no result line in $log"
  exit 1
fi
exit 0

//--- verification/ldpc_vstep_tb.sv
// default parameters only, so a sum or llr of 0 or more is bit one; frames are at most 21 columns
`timescale 1ns/1ps

module ldpc_vstep_tb import ldpc_vstep_pkg::*; ();

  // one stimulus beat, with the gaps that come before it
  typedef struct packed {
    logic  idle_before;   // one ival low cycle first
    logic  stall_before;  // one iclkena low cycle first
    strb_t strb;
    llr_t  llr;
    node_t cnode;
    col_t  col;
  } beat_t;

  logic       iclk;
  logic       ireset;
  logic       iclkena;
  logic       iload_iter;
  logic       ival;
  strb_t      istrb;
  llr_t       illr;
  node_t      icnode;
  col_t       icol_idx;
  logic       omsg_val;
  node_t      omsg;
  col_t       omsg_col;
  logic       oword_val;
  word_t      oword;
  byte_addr_t oword_addr;
  logic       ofrm_val;
  err_cnt_t   oerr_cnt;

  int    exp_msg[$];    // reference extrinsic values, column order
  int    exp_mcol[$];
  int    exp_word[$];
  int    exp_addr[$];
  int    exp_err[$];
  int    checks      = 0;
  int    errors      = 0;
  int    quiet_cnt   = 0;  // enabled cycles checked up to one past the first eop
  int    quiet_err   = 0;
  int    beat_total  = 0;
  int    cycle_cnt   = 0;
  int    cycle_limit = 200;
  int    total_fail  = 0;
  bit    eop_seen    = 1'b0;
  bit    quiet_done  = 1'b0;
  string test_name   = "reset_quiet";

  ldpc_vstep_top uut (.*);

  bind ldpc_vstep_top ldpc_vstep_assertions u_chk (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .ival      (ival),
    .istrb     (istrb),
    .omsg_val  (omsg_val),
    .oword_val (oword_val),
    .ofrm_val  (ofrm_val)
  );

  initial begin
    iclk = 1'b0;
    forever #4 iclk = ~iclk;  // 8 ns period
  end

  // --------------------
  // reference and checks
  // --------------------
  function automatic int clip_msg(input int v);
    if (v > 127) return 127;    // top of the 8 bit message range
    if (v < -128) return -128;
    return v;
  endfunction

  task automatic check_val(input string what, input int exp_v, input int act_v);
    checks++;
    assert (act_v == exp_v) else begin
      errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic report_unexpected(input string what);
    errors++;
    $display("%s: %s came out while none was expected", test_name, what);
  endtask

  // one beat per call, gaps first; the beat is taken at the following edge
  task automatic drive_beat(input beat_t b);
    if (b.stall_before) begin
      @(posedge iclk);
      iclkena <= 1'b0;          // freeze, held beat is not taken twice
    end
    if (b.idle_before) begin
      @(posedge iclk);
      iclkena <= 1'b1;
      ival    <= 1'b0;
      istrb   <= '0;
    end
    @(posedge iclk);
    iclkena  <= 1'b1;
    ival     <= 1'b1;
    istrb    <= b.strb;
    illr     <= b.llr;
    icnode   <= b.cnode;
    icol_idx <= b.col;
  endtask

  // mode 1: forced saturation in columns 0..2, mode 2: degree 2 run then gaps
  task automatic run_frame(input string name, input int ncol, input bit load, input int mode);
    beat_t beats[$];
    beat_t b;
    int    deg;
    int    llr_v;
    int    msgs[16];
    int    sum;
    int    dec_bit;
    int    chan_bit;
    int    word;
    int    pos;
    int    addr;
    int    nerr;
    int    chk0;
    int    err0;
    word = 0;
    pos  = 0;
    addr = 0;
    nerr = 0;
    for (int c = 0; c < ncol; c++) begin
      deg   = 2 + int'($urandom % 15);
      llr_v = int'(llr_t'($urandom));
      for (int k = 0; k < 16; k++) msgs[k] = int'($urandom % 241) - 120;
      if (mode == 1 && c < 2) begin
        deg   = 16;                         // sums near the 12 bit limit
        llr_v = (c == 0) ? 7 : -8;
        for (int k = 0; k < 16; k++) msgs[k] = (c == 0) ? 127 : -120;
      end
      if (mode == 1 && c == 2) begin
        deg     = 3;
        llr_v   = 0;
        msgs[0] = 127;
        msgs[1] = 127;
        msgs[2] = -128;                     // 126 + 128 clips to 127
      end
      if (mode == 2 && c < 8) deg = 2;
      sum = llr_v;
      for (int k = 0; k < deg; k++) sum += msgs[k];
      for (int k = 0; k < deg; k++) begin
        exp_msg.push_back(clip_msg(sum - msgs[k]));
        exp_mcol.push_back(c);
      end
      dec_bit  = (sum >= 0) ? 1 : 0;
      chan_bit = (llr_v >= 0) ? 1 : 0;
      if (!load && dec_bit != chan_bit) nerr++;
      word |= (load ? chan_bit : dec_bit) << pos;  // lsb is the first column
      pos++;
      if (pos == 8 || c == ncol - 1) begin
        exp_word.push_back(word);
        exp_addr.push_back(addr);
        word = 0;
        pos  = 0;
        addr++;
      end
      for (int k = 0; k < deg; k++) begin
        b.idle_before  = (mode == 2 && c >= 8) ? ($urandom % 4 == 0) : 1'b0;
        b.stall_before = (mode == 2 && c >= 8) ? ($urandom % 5 == 0) : 1'b0;
        b.strb.sof     = (c == 0 && k == 0);
        b.strb.sop     = (k == 0);
        b.strb.eop     = (k == deg - 1);
        b.strb.eof     = (c == ncol - 1 && k == deg - 1);
        b.llr          = llr_t'(llr_v);
        b.cnode        = node_t'(msgs[k]);
        b.col          = col_t'(c);
        beats.push_back(b);
        beat_total += 1 + int'(b.idle_before) + int'(b.stall_before);
      end
    end
    exp_err.push_back(nerr);
    cycle_limit = 2 * beat_total + 200;
    chk0 = checks;
    err0 = errors;
    test_name = name;
    @(posedge iclk);
    iload_iter <= load;
    foreach (beats[i]) drive_beat(beats[i]);
    @(posedge iclk);
    iclkena <= 1'b1;
    ival    <= 1'b0;
    istrb   <= '0;
    // done once every expected message, byte and count has come back
    while (exp_msg.size() != 0 || exp_word.size() != 0 || exp_err.size() != 0) begin
      @(posedge iclk);
    end
    $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // --------------------
  // output monitor
  // --------------------
  // mid-cycle sampling, each output value counted once in the enabled cycle that ends it
  always @(negedge iclk) begin
    if (!ireset && iclkena) begin
      if (!quiet_done) begin
        quiet_cnt++;
        checks++;
        assert (!omsg_val && !oword_val && !ofrm_val) else begin
          errors++;
          quiet_err++;
          $display("reset_quiet: output strobe high before the first eop plus 2 cycles");
        end
        quiet_done = eop_seen;                       // the cycle after the eop is the last
        eop_seen   = eop_seen || (ival && istrb.eop);
      end
      if (omsg_val) begin
        if (exp_msg.size() == 0) begin
          report_unexpected("extrinsic message");
        end else begin
          check_val("omsg", exp_msg.pop_front(), int'(omsg));
          check_val("omsg_col", exp_mcol.pop_front(), int'(omsg_col));
        end
      end
      if (oword_val) begin
        if (exp_word.size() == 0) begin
          report_unexpected("decision byte");
        end else begin
          check_val("oword", exp_word.pop_front(), int'(oword));
          check_val("oword_addr", exp_addr.pop_front(), int'(oword_addr));
        end
      end
      if (ofrm_val) begin
        if (exp_err.size() == 0) report_unexpected("frame report");
        else check_val("oerr_cnt", exp_err.pop_front(), int'(oerr_cnt));
      end
    end
  end

  // watchdog
  always @(posedge iclk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: results still missing after %0d cycles", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin
    void'($urandom(32'h25711eba));
    ireset     = 1'b1;
    iclkena    = 1'b0;
    iload_iter = 1'b0;
    ival       = 1'b0;
    istrb      = '0;
    illr       = '0;
    icnode     = '0;
    icol_idx   = '0;
    repeat (3) @(posedge iclk);
    ireset  <= 1'b0;
    iclkena <= 1'b1;
    run_frame("extrinsic", 12, 1'b0, 1);
    $display("test reset_quiet: %0d cycles checked, %0d errors", quiet_cnt, quiet_err);
    run_frame("hard_decision", 21, 1'b0, 0);    // two full bytes and one of 5 bits
    run_frame("bypass", 10, 1'b1, 0);
    run_frame("flow", 20, 1'b0, 2);
    repeat (4) @(posedge iclk);
    total_fail = errors + uut.u_chk.fail_cnt;
    $display("tests 5, checks %0d, errors %0d, assertion failures %0d",
             checks, errors, uut.u_chk.fail_cnt);
    if (total_fail == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verification/ldpc_vstep_assertions.sv
// assumes columns of at least two beats; pulse widths are counted in enabled cycles only
`timescale 1ns/1ps

module ldpc_vstep_assertions import ldpc_vstep_pkg::*; (
  input logic  iclk,
  input logic  ireset,
  input logic  iclkena,
  input logic  ival,
  input strb_t istrb,
  input logic  omsg_val,
  input logic  oword_val,
  input logic  ofrm_val
);

  int fail_cnt = 0;  // failed properties so far

  // --------------------
  // pulse widths
  // --------------------
  frm_pulse: assert property (@(posedge iclk) disable iff (ireset)
      (ofrm_val && iclkena) |=> !ofrm_val)   // frozen cycles keep it high, enabled ones drop it
    else begin
      $error("ofrm_val high for a second enabled cycle");
      fail_cnt++;
    end

  word_pulse: assert property (@(posedge iclk) disable iff (ireset)
      (oword_val && iclkena) |=> !oword_val)
    else begin
      $error("oword_val high for a second enabled cycle");
      fail_cnt++;
    end

  // an idle update stage needs two cycles from eop to the first message
  msg_gap: assert property (@(posedge iclk) disable iff (ireset)
      (iclkena && ival && istrb.eop && !omsg_val) |=> !omsg_val)
    else begin
      $error("omsg_val high in the first cycle after an eop beat");
      fail_cnt++;
    end

  // --------------------
  // reset
  // --------------------
  reset_quiet: assert property (@(posedge iclk)
      ireset |-> !(omsg_val || oword_val || ofrm_val))
    else begin
      $error("output strobe high during reset");
      fail_cnt++;
    end

endmodule

//--- verilog/ldpc_vstep_top.sv
// vertical step only; stream must follow the beat rules, there is no back-pressure
`timescale 1ns/1ps

module ldpc_vstep_top import ldpc_vstep_pkg::*; #(
  parameter bit pDO_LLR_INVERSION = 1'b0,
  parameter int pFIFO_DEPTH_W     = 5
) (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,    // low freezes the whole pipeline
  input  logic       iload_iter,
  input  logic       ival,
  input  strb_t      istrb,
  input  llr_t       illr,
  input  node_t      icnode,
  input  col_t       icol_idx,
  output logic       omsg_val,
  output node_t      omsg,
  output col_t       omsg_col,
  output logic       oword_val,
  output word_t      oword,
  output byte_addr_t oword_addr,
  output logic       ofrm_val,
  output err_cnt_t   oerr_cnt
);

  logic      vnode_pre_val;
  node_num_t vnode_pre_num_m1;
  logic      vnode_val;
  node_sum_t vnode_sum;
  logic      bitval;
  logic      bitsop;
  logic      biteop;
  logic      bitdat;
  logic      biterr;
  col_t      bitaddr;    // column of the finished sum
  node_t     fifo_dat;
  logic      fifo_read;

  //--------------------
  // accumulator
  //--------------------
  ldpc_vnode_sum #(
    .pDO_LLR_INVERSION (pDO_LLR_INVERSION)
  ) u_sum (
    .iclk              (iclk),
    .ireset            (ireset),
    .iclkena           (iclkena),
    .iload_iter        (iload_iter),
    .ival              (ival),
    .istrb             (istrb),
    .illr              (illr),
    .icnode            (icnode),
    .icol_idx          (icol_idx),
    .ovnode_val        (vnode_val),
    .ovnode_sum        (vnode_sum),
    .ovnode_pre_val    (vnode_pre_val),
    .ovnode_pre_num_m1 (vnode_pre_num_m1),
    .obitval           (bitval),
    .obitsop           (bitsop),
    .obiteop           (biteop),
    .obitdat           (bitdat),
    .obiterr           (biterr),
    .obitaddr          (bitaddr)
  );

  // every beat's message is parked until its column sum is known
  ldpc_msg_fifo #(
    .pFIFO_DEPTH_W (pFIFO_DEPTH_W)
  ) u_fifo (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .iwrite  (ival),
    .iwdat   (icnode),
    .iread   (fifo_read),
    .ordat   (fifo_dat)
  );

  //--------------------
  // extrinsic and decisions
  //--------------------
  ldpc_vnode_update u_update (
    .iclk              (iclk),
    .ireset            (ireset),
    .iclkena           (iclkena),
    .ivnode_pre_val    (vnode_pre_val),
    .ivnode_pre_num_m1 (vnode_pre_num_m1),
    .ivnode_val        (vnode_val),
    .ivnode_sum        (vnode_sum),
    .ififo_dat         (fifo_dat),
    .icol              (bitaddr),
    .ofifo_read        (fifo_read),
    .omsg_val          (omsg_val),
    .omsg              (omsg),
    .omsg_col          (omsg_col)
  );

  ldpc_hd_collect u_hd (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .ibitval    (bitval),
    .ibitsop    (bitsop),
    .ibiteop    (biteop),
    .ibitdat    (bitdat),
    .ibiterr    (biterr),
    .oword_val  (oword_val),
    .oword      (oword),
    .oword_addr (oword_addr),
    .ofrm_val   (ofrm_val),
    .oerr_cnt   (oerr_cnt)
  );

endmodule

//--- verilog/ldpc_hd_collect.sv
// a frame must start with ibitsop; bit i of a byte is column 8*addr+i, unused bits of a short byte are 0
`timescale 1ns/1ps

module ldpc_hd_collect import ldpc_vstep_pkg::*; (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  input  logic       ibitval,
  input  logic       ibitsop,
  input  logic       ibiteop,
  input  logic       ibitdat,
  input  logic       ibiterr,
  output logic       oword_val,
  output word_t      oword,
  output byte_addr_t oword_addr,
  output logic       ofrm_val,
  output err_cnt_t   oerr_cnt
);

  bit_idx_t   bit_cnt;    // next bit position
  bit_idx_t   bit_idx;
  byte_addr_t addr_q;     // address of the byte being filled
  byte_addr_t addr;
  word_t      word_q;
  word_t      word;
  err_cnt_t   err_q;
  err_cnt_t   err;
  logic       word_done;

  //--------------------
  // next byte / count
  //--------------------
  always_comb begin
    bit_idx       = ibitsop ? '0 : bit_cnt;          // frame start restarts everything
    addr          = ibitsop ? '0 : addr_q;
    err           = (ibitsop ? '0 : err_q) + ibiterr;
    word          = (bit_idx == '0) ? '0 : word_q;   // fresh byte starts cleared
    word[bit_idx] = ibitdat;                         // lsb first
    word_done     = (bit_idx == '1) | ibiteop;       // full byte or frame end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      bit_cnt   <= '0;
      addr_q    <= '0;
      err_q     <= '0;
      oword_val <= 1'b0;
      ofrm_val  <= 1'b0;
    end else if (iclkena) begin
      oword_val <= ibitval & word_done;
      ofrm_val  <= ibitval & ibiteop;
      if (ibitval) begin
        bit_cnt <= bit_idx + 1'b1;                   // wraps to 0 after bit 7
        addr_q  <= word_done ? addr + 1'b1 : addr;
        err_q   <= err;
      end
    end
  end

  //--------------------
  // output registers
  //--------------------
  always_ff @(posedge iclk) begin
    if (iclkena & ibitval) begin
      word_q <= word;
      if (word_done) begin
        oword      <= word;
        oword_addr <= addr;
      end
      if (ibiteop) begin
        oerr_cnt <= err;  // frame total
      end
    end
  end

endmodule

//--- verilog/ldpc_vnode_update.sv
// pops one message per cycle; up to 8 finished columns may wait while a longer one drains
`timescale 1ns/1ps

module ldpc_vnode_update import ldpc_vstep_pkg::*; (
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  logic      ivnode_pre_val,
  input  node_num_t ivnode_pre_num_m1,
  input  logic      ivnode_val,
  input  node_sum_t ivnode_sum,
  input  node_t     ififo_dat,
  input  col_t      icol,
  output logic      ofifo_read,
  output logic      omsg_val,
  output node_t     omsg,
  output col_t      omsg_col
);

  localparam int q_w = 3;  // waiting column queue, 8 entries

  typedef struct packed {
    node_sum_t sum;
    col_t      col;
    node_num_t num_m1;
  } col_desc_t;

  col_desc_t  q_mem [2**q_w];
  logic [q_w:0] q_wptr;
  logic [q_w:0] q_rptr;
  logic       q_empty;
  logic       q_push;
  logic       q_pop;
  node_num_t  pre_num_m1;  // degree of the column whose sum lands next
  col_desc_t  new_desc;    // column arriving on ivnode_val
  col_desc_t  cur;         // column being drained
  col_desc_t  src;         // column served this cycle
  node_num_t  cur_rem;     // messages left after the current pop
  node_num_t  src_rem;
  logic       active;      // cur still has messages
  logic       serve;
  node_diff_t diff;

  //--------------------
  // column select
  //--------------------
  assign new_desc = '{sum: ivnode_sum, col: icol, num_m1: pre_num_m1};
  assign q_empty  = (q_wptr == q_rptr);

  always_comb begin
    src     = cur;
    src_rem = cur_rem;
    if (!active) begin
      // oldest waiting column first, else the one landing now
      src     = q_empty ? new_desc : q_mem[q_rptr[q_w-1:0]];
      src_rem = src.num_m1;
    end
  end

  assign serve      = active | ~q_empty | ivnode_val;
  assign q_pop      = ~active & ~q_empty;
  assign q_push     = ivnode_val & (active | ~q_empty);  // busy, park it
  assign ofifo_read = serve;                              // one message per served cycle

  assign diff = node_diff_t'(src.sum) - node_diff_t'(ififo_dat);

  //--------------------
  // control
  //--------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      active   <= 1'b0;
      cur_rem  <= '0;
      q_wptr   <= '0;
      q_rptr   <= '0;
      omsg_val <= 1'b0;
    end else if (iclkena) begin
      omsg_val <= serve;
      if (serve) begin
        active  <= (src_rem != '0);  // last message leaves the engine free
        cur_rem <= src_rem - 1'b1;
      end
      if (q_push) begin
        q_wptr <= q_wptr + 1'b1;
      end
      if (q_pop) begin
        q_rptr <= q_rptr + 1'b1;
      end
    end
  end

  //--------------------
  // data path
  //--------------------
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (ivnode_pre_val) begin
        pre_num_m1 <= ivnode_pre_num_m1;  // arrives one cycle before the sum
      end
      if (q_push) begin
        q_mem[q_wptr[q_w-1:0]] <= new_desc;
      end
      if (serve) begin
        cur      <= src;
        omsg     <= sat_node(diff);  // extrinsic = total minus own message
        omsg_col <= src.col;
      end
    end
  end

endmodule

//--- verilog/ldpc_msg_fifo.sv
// no full or empty check, the stream rules keep the fill below 2**pFIFO_DEPTH_W messages
`timescale 1ns/1ps

module ldpc_msg_fifo import ldpc_vstep_pkg::*; #(
  parameter int pFIFO_DEPTH_W = 5  // log2 depth, 32 holds two max degree columns
) (
  input  logic  iclk,
  input  logic  ireset,
  input  logic  iclkena,
  input  logic  iwrite,
  input  node_t iwdat,
  input  logic  iread,
  output node_t ordat   // show-ahead, head of queue
);

  localparam int depth = 2**pFIFO_DEPTH_W;

  node_t                    mem [depth];
  logic [pFIFO_DEPTH_W-1:0] wptr;   // next free slot
  logic [pFIFO_DEPTH_W-1:0] rptr;   // oldest message

  //--------------------
  // pointers
  //--------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr <= '0;
      rptr <= '0;
    end else if (iclkena) begin
      if (iwrite) begin
        wptr <= wptr + 1'b1;  // wraps at depth
      end
      if (iread) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  //--------------------
  // storage
  //--------------------
  always_ff @(posedge iclk) begin
    if (iclkena & iwrite) begin
      mem[wptr] <= iwdat;
    end
  end

  // read is asynchronous so the popped message is usable in the pop cycle
  assign ordat = mem[rptr];

endmodule

//--- verilog/ldpc_vnode_sum.sv
// llr and column index must stay constant over a column of 2..16 beats; sum wraps past 12 bits
`timescale 1ns/1ps

module ldpc_vnode_sum import ldpc_vstep_pkg::*; #(
  parameter bit pDO_LLR_INVERSION = 1'b0  // 0: value >= 0 is bit one, 1: value <= 0 is bit one
) (
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  logic      iload_iter,         // bypass, channel decision goes out as is
  input  logic      ival,
  input  strb_t     istrb,
  input  llr_t      illr,
  input  node_t     icnode,
  input  col_t      icol_idx,
  output logic      ovnode_val,         // sum ready, 1 cycle after eop beat
  output node_sum_t ovnode_sum,
  output logic      ovnode_pre_val,     // look-ahead, in the eop beat itself
  output node_num_t ovnode_pre_num_m1,  // column degree - 1, valid with pre_val
  output logic      obitval,
  output logic      obitsop,            // first column of a frame
  output logic      obiteop,            // last column of a frame
  output logic      obitdat,
  output logic      obiterr,
  output col_t      obitaddr
);

  logic eof_q;    // eof flag of the last accepted beat
  logic chan_hd;  // channel decision of current column
  logic dec_hd;   // decoded decision from the column sum

  //--------------------
  // control
  //--------------------
  assign ovnode_pre_val = ival & istrb.eop;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ovnode_val <= 1'b0;
      obitsop    <= 1'b0;
    end else if (iclkena) begin
      ovnode_val <= ival & istrb.eop;
      // flag raised at frame start, dropped once the first bit has gone out
      if (ival & istrb.sof & istrb.sop) begin
        obitsop <= 1'b1;
      end else if (ovnode_val) begin
        obitsop <= 1'b0;
      end
    end
  end

  //--------------------
  // accumulator
  //--------------------
  always_ff @(posedge iclk) begin
    if (iclkena & ival) begin
      // sop restarts from the llr, every beat adds its message
      ovnode_sum <= (istrb.sop ? node_sum_t'(illr) : ovnode_sum) + node_sum_t'(icnode);
      // counts one ahead so it equals degree - 1 during the eop beat
      ovnode_pre_num_m1 <= istrb.sop ? node_num_t'(1) : ovnode_pre_num_m1 + 1'b1;
      eof_q    <= istrb.eof;
      chan_hd  <= pDO_LLR_INVERSION ? (illr <= 0) : (illr >= 0);
      obitaddr <= icol_idx;                     // held for the whole column
    end
  end

  //--------------------
  // hard decision
  //--------------------
  assign dec_hd = pDO_LLR_INVERSION ? (ovnode_sum <= 0) : (ovnode_sum >= 0);

  assign obitval = ovnode_val;
  assign obiteop = eof_q;
  assign obitdat = iload_iter ? chan_hd : dec_hd;
  assign obiterr = iload_iter ? 1'b0 : (dec_hd ^ chan_hd);  // flips against the channel

endmodule

//--- verilog/ldpc_vstep_pkg.sv
// widths are fixed here: column degree up to 16, frame up to 256 columns, 12 bit column sum
package ldpc_vstep_pkg;

  //--------------------
  // widths
  //--------------------
  localparam int llr_w       = 4;                        // channel llr
  localparam int node_w      = 8;                        // check node / extrinsic message
  localparam int sum_w       = 12;                       // llr plus up to 16 messages
  localparam int num_w       = 4;                        // degree - 1
  localparam int col_w       = 8;                        // column index
  localparam int err_w       = 8;                        // decision errors per frame
  localparam int byte_w      = 8;                        // hard decisions per output word
  localparam int bit_idx_w   = $clog2(byte_w);
  localparam int byte_addr_w = col_w - bit_idx_w;        // one address per 8 columns
  localparam int diff_w      = sum_w + 1;                // sum minus message never wraps

  //--------------------
  // types
  //--------------------
  typedef logic signed [llr_w-1:0]  llr_t;
  typedef logic signed [node_w-1:0] node_t;
  typedef logic signed [sum_w-1:0]  node_sum_t;
  typedef logic signed [diff_w-1:0] node_diff_t;
  typedef logic [num_w-1:0]         node_num_t;
  typedef logic [col_w-1:0]         col_t;
  typedef logic [err_w-1:0]         err_cnt_t;
  typedef logic [byte_w-1:0]        word_t;
  typedef logic [bit_idx_w-1:0]     bit_idx_t;
  typedef logic [byte_addr_w-1:0]   byte_addr_t;

  // stream strobes, one beat may carry several
  typedef struct packed {
    logic sof;  // first beat of frame
    logic sop;  // first beat of column
    logic eop;  // last beat of column
    logic eof;  // last beat of frame
  } strb_t;

  //--------------------
  // saturation rule
  //--------------------
  localparam node_diff_t node_max = 2**(node_w-1) - 1;   // +127
  localparam node_diff_t node_min = -(2**(node_w-1));    // -128

  // clip a wide difference to the message range
  function automatic node_t sat_node(input node_diff_t v);
    if (v > node_max) begin
      return node_max[node_w-1:0];
    end
    if (v < node_min) begin
      return node_min[node_w-1:0];
    end
    return v[node_w-1:0];
  endfunction

endpackage
